//--- common/udp_echo_config.svh
// UDP echo configuration
// Echo port, local address, reply TTL and queue depths
`ifndef UDP_ECHO_CONFIG_SVH
`define UDP_ECHO_CONFIG_SVH

// Frames to this destination port get a reply
`define ECHO_PORT 16'd1234

// 192.168.1.128
`define LOCAL_IP 32'hc0a8_0180

`define REPLY_TTL 8'd64

// Queue depths in entries
`define PAYLOAD_FIFO_DEPTH 64
`define HDR_FIFO_DEPTH 4

`endif

//--- common/udp_pkg.sv
// UDP header types
// Addresses, port numbers and the header that travels beside the payload

package udp_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // IP fields kept by the echo path, followed by the UDP fields
    typedef struct packed {
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        logic [7:0]  ttl;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] length;
    } udp_hdr_t;

endpackage

//--- common/stream_pkg.sv
// Payload stream types
// One byte per beat, last marks the end of a frame

package stream_pkg;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } payload_beat_t;

endpackage

//--- common/udp_stream_if.sv
// UDP frame stream
// Header channel and payload channel, each with valid/ready handshake

`timescale 1ns/100ps

interface udp_stream_if
    import udp_pkg::*, stream_pkg::*;
();

    // Header channel
    logic          hdr_valid;
    logic          hdr_ready;
    udp_hdr_t      hdr;

    // Payload channel
    logic          pay_valid;
    logic          pay_ready;
    payload_beat_t pay;

    modport src (
        output hdr_valid, hdr, pay_valid, pay,
        input  hdr_ready, pay_ready
    );

    modport snk (
        input  hdr_valid, hdr, pay_valid, pay,
        output hdr_ready, pay_ready
    );

endinterface

//--- source/sync_fifo.sv
// Synchronous FIFO
// Circular buffer with valid/ready on both sides, item type set by parameter

`timescale 1ns/100ps

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  i_wr_valid,
    input  item_t i_wr_data,
    output logic  o_wr_ready,
    output logic  o_rd_valid,
    output item_t o_rd_data,
    input  logic  i_rd_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t           mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            wr_en;
    logic            rd_en;

    assign o_wr_ready = (count != CW'(DEPTH));
    assign o_rd_valid = (count != '0);
    assign o_rd_data  = mem[rd_ptr];

    assign wr_en = i_wr_valid && o_wr_ready;
    assign rd_en = o_rd_valid && i_rd_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(wr_en) - CW'(rd_en);
        end
    end

    // A full queue stays full until something is read
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        (count == CW'(DEPTH)) && !rd_en |=> (count == CW'(DEPTH)) && $stable(wr_ptr));

    // An empty queue stays empty until something is written
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        (count == '0) && !wr_en |=> (count == '0) && $stable(rd_ptr));

endmodule

//--- source/port_filter_fsm.sv
// Port filter
// Passes frames for the echo port on with a reply header,
// consumes and discards frames for every other port

`timescale 1ns/100ps

`include "udp_echo_config.svh"

module port_filter_fsm
    import udp_pkg::*, stream_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             i_hdr_valid,
    input  udp_hdr_t         i_hdr,
    output logic             o_hdr_ready,
    input  logic             i_pay_valid,
    input  payload_beat_t    i_pay,
    output logic             o_pay_ready,
    udp_stream_if.src        o_filt
);

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DROP
    } state_t;

    state_t state;
    state_t state_next;
    logic   dst_match;

    assign dst_match = (i_hdr.dst_port == `ECHO_PORT);

    // Reply goes back to the sender with the ports swapped
    assign o_filt.hdr = '{
        src_ip:   `LOCAL_IP,
        dst_ip:   i_hdr.src_ip,
        ttl:      `REPLY_TTL,
        src_port: i_hdr.dst_port,
        dst_port: i_hdr.src_port,
        length:   i_hdr.length
    };
    assign o_filt.pay = i_pay;

    always_comb begin
        o_hdr_ready      = 1'b0;
        o_pay_ready      = 1'b0;
        o_filt.hdr_valid = 1'b0;
        o_filt.pay_valid = 1'b0;
        state_next       = state;
        case (state)
            IDLE: begin
                o_filt.hdr_valid = i_hdr_valid && dst_match;
                // Other ports are always taken
                o_hdr_ready = dst_match ? o_filt.hdr_ready : 1'b1;
                if (i_hdr_valid && o_hdr_ready) begin
                    state_next = dst_match ? FORWARD : DROP;
                end
            end
            FORWARD: begin
                o_filt.pay_valid = i_pay_valid;
                o_pay_ready      = o_filt.pay_ready;
                if (i_pay_valid && o_pay_ready && i_pay.last) begin
                    state_next = IDLE;
                end
            end
            DROP: begin
                o_pay_ready = 1'b1;
                if (i_pay_valid && i_pay.last) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Payload only moves once its header is through
    a_no_pay_in_idle: assert property (@(posedge clk) disable iff (rst)
        i_pay_valid && o_pay_ready |-> state != IDLE);

endmodule

//--- source/reply_sender.sv
// Reply sender
// Sends each queued header, then the payload of that frame,
// and shows the first byte of every reply on the LEDs

`timescale 1ns/100ps

module reply_sender
    import udp_pkg::*, stream_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    udp_stream_if.snk        i_queued,
    output logic             o_hdr_valid,
    output udp_hdr_t         o_hdr,
    input  logic             i_hdr_ready,
    output logic             o_pay_valid,
    output payload_beat_t    o_pay,
    input  logic             i_pay_ready,
    output logic [7:0]       o_led
);

    typedef enum logic {
        HEADER,
        PAYLOAD
    } state_t;

    state_t state;
    logic   first_beat;

    assign o_hdr = i_queued.hdr;
    assign o_pay = i_queued.pay;

    // Each channel is only open in its own state
    assign o_hdr_valid        = (state == HEADER) && i_queued.hdr_valid;
    assign i_queued.hdr_ready = (state == HEADER) && i_hdr_ready;
    assign o_pay_valid        = (state == PAYLOAD) && i_queued.pay_valid;
    assign i_queued.pay_ready = (state == PAYLOAD) && i_pay_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= HEADER;
            first_beat <= 1'b1;
            o_led      <= 8'h00;
        end else begin
            case (state)
                HEADER: begin
                    if (o_hdr_valid && i_hdr_ready) begin
                        state <= PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (o_pay_valid && i_pay_ready) begin
                        if (first_beat) begin
                            o_led <= o_pay.data;
                        end
                        // Armed again for the next reply
                        first_beat <= o_pay.last;
                        if (o_pay.last) begin
                            state <= HEADER;
                        end
                    end
                end
                default: state <= HEADER;
            endcase
        end
    end

    // Stalled outputs hold, which relies on the queues behind them
    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        o_hdr_valid && !i_hdr_ready |=> o_hdr_valid && $stable(o_hdr));

    a_pay_hold: assert property (@(posedge clk) disable iff (rst)
        o_pay_valid && !i_pay_ready |=> o_pay_valid && $stable(o_pay));

endmodule

//--- source/udp_echo_top.sv
// UDP echo top level
// Filters incoming frames on the echo port, queues headers and
// payload, and sends the replies back out

`timescale 1ns/100ps

`include "udp_echo_config.svh"

module udp_echo_top
    import udp_pkg::*, stream_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Input frames
    input  logic        i_hdr_valid,
    output logic        o_hdr_ready,
    input  logic [31:0] i_hdr_src_ip,
    input  logic [31:0] i_hdr_dst_ip,
    input  logic [7:0]  i_hdr_ttl,
    input  logic [15:0] i_hdr_src_port,
    input  logic [15:0] i_hdr_dst_port,
    input  logic [15:0] i_hdr_length,
    input  logic        i_pay_valid,
    output logic        o_pay_ready,
    input  logic [7:0]  i_pay_data,
    input  logic        i_pay_last,
    // Reply frames
    output logic        o_hdr_valid,
    input  logic        i_hdr_ready,
    output logic [31:0] o_hdr_src_ip,
    output logic [31:0] o_hdr_dst_ip,
    output logic [7:0]  o_hdr_ttl,
    output logic [15:0] o_hdr_src_port,
    output logic [15:0] o_hdr_dst_port,
    output logic [15:0] o_hdr_length,
    output logic        o_pay_valid,
    input  logic        i_pay_ready,
    output logic [7:0]  o_pay_data,
    output logic        o_pay_last,
    output logic [7:0]  o_led
);

    udp_hdr_t      in_hdr;
    payload_beat_t in_pay;
    udp_hdr_t      out_hdr;
    payload_beat_t out_pay;

    udp_stream_if filt_if ();
    udp_stream_if queued_if ();

    // Pack the plain ports into structs
    assign in_hdr = '{
        src_ip:   i_hdr_src_ip,
        dst_ip:   i_hdr_dst_ip,
        ttl:      i_hdr_ttl,
        src_port: i_hdr_src_port,
        dst_port: i_hdr_dst_port,
        length:   i_hdr_length
    };
    assign in_pay = '{data: i_pay_data, last: i_pay_last};

    assign o_hdr_src_ip   = out_hdr.src_ip;
    assign o_hdr_dst_ip   = out_hdr.dst_ip;
    assign o_hdr_ttl      = out_hdr.ttl;
    assign o_hdr_src_port = out_hdr.src_port;
    assign o_hdr_dst_port = out_hdr.dst_port;
    assign o_hdr_length   = out_hdr.length;
    assign o_pay_data     = out_pay.data;
    assign o_pay_last     = out_pay.last;

    port_filter_fsm filter_i (
        .clk         (clk),
        .rst         (rst),
        .i_hdr_valid (i_hdr_valid),
        .i_hdr       (in_hdr),
        .o_hdr_ready (o_hdr_ready),
        .i_pay_valid (i_pay_valid),
        .i_pay       (in_pay),
        .o_pay_ready (o_pay_ready),
        .o_filt      (filt_if.src)
    );

    // Several reply headers may wait here
    sync_fifo #(
        .item_t (udp_hdr_t),
        .DEPTH  (`HDR_FIFO_DEPTH)
    ) hdr_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_wr_valid (filt_if.hdr_valid),
        .i_wr_data  (filt_if.hdr),
        .o_wr_ready (filt_if.hdr_ready),
        .o_rd_valid (queued_if.hdr_valid),
        .o_rd_data  (queued_if.hdr),
        .i_rd_ready (queued_if.hdr_ready)
    );

    sync_fifo #(
        .item_t (payload_beat_t),
        .DEPTH  (`PAYLOAD_FIFO_DEPTH)
    ) pay_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_wr_valid (filt_if.pay_valid),
        .i_wr_data  (filt_if.pay),
        .o_wr_ready (filt_if.pay_ready),
        .o_rd_valid (queued_if.pay_valid),
        .o_rd_data  (queued_if.pay),
        .i_rd_ready (queued_if.pay_ready)
    );

    reply_sender sender_i (
        .clk         (clk),
        .rst         (rst),
        .i_queued    (queued_if.snk),
        .o_hdr_valid (o_hdr_valid),
        .o_hdr       (out_hdr),
        .i_hdr_ready (i_hdr_ready),
        .o_pay_valid (o_pay_valid),
        .o_pay       (out_pay),
        .i_pay_ready (i_pay_ready),
        .o_led       (o_led)
    );

endmodule

//--- verification/udp_echo_checker.sv
// UDP echo checker
// Models the expected replies from the accepted input frames and
// compares every output transfer, the LEDs and the hold rule

`timescale 1ns/100ps

`include "udp_echo_config.svh"

module udp_echo_checker
    import udp_pkg::*, stream_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          i_in_hdr_valid,
    input  logic          i_in_hdr_ready,
    input  udp_hdr_t      i_in_hdr,
    input  logic          i_in_pay_valid,
    input  logic          i_in_pay_ready,
    input  payload_beat_t i_in_pay,
    input  logic          i_out_hdr_valid,
    input  logic          i_out_hdr_ready,
    input  udp_hdr_t      i_out_hdr,
    input  logic          i_out_pay_valid,
    input  logic          i_out_pay_ready,
    input  payload_beat_t i_out_pay,
    input  logic [7:0]    i_led,
    input  logic          i_done,
    output int            o_pending,
    output logic          o_finished,
    output int            o_errors
);

    udp_hdr_t      exp_hdr_q[$];
    payload_beat_t exp_pay_q[$];
    int            hdr_errors = 0;
    int            pay_errors = 0;
    int            led_errors = 0;
    int            other_errors = 0;
    int            hdr_count = 0;
    int            pay_count = 0;
    logic          after_reset = 1'b0;
    logic          in_frame;
    logic          in_matched;
    logic          out_open;
    logic          out_first;
    logic          led_pending;
    logic [7:0]    led_expected;
    logic          hdr_stalled;
    logic          pay_stalled;
    udp_hdr_t      prev_hdr;
    payload_beat_t prev_pay;

    initial begin
        o_pending  = 0;
        o_finished = 1'b0;
        o_errors   = 0;
    end

    function automatic int field_error(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk) begin
        udp_hdr_t      exp_h;
        payload_beat_t exp_b;
        if (rst) begin
            after_reset = 1'b1;
            in_frame    = 1'b0;
            in_matched  = 1'b0;
            out_open    = 1'b0;
            out_first   = 1'b1;
            led_pending = 1'b0;
            hdr_stalled = 1'b0;
            pay_stalled = 1'b0;
        end else begin
            if (after_reset) begin
                other_errors += field_error("o_hdr_valid", i_out_hdr_valid, 0);
                other_errors += field_error("o_pay_valid", i_out_pay_valid, 0);
                other_errors += field_error("o_led", i_led, 0);
                other_errors += field_error("o_hdr_ready", i_in_hdr_ready, 1);
                other_errors += field_error("o_pay_ready", i_in_pay_ready, 0);
                after_reset = 1'b0;
            end
            // LED was loaded on the previous edge
            if (led_pending) begin
                led_errors += field_error("o_led", i_led, led_expected);
                led_pending = 1'b0;
            end
            if (hdr_stalled && (!i_out_hdr_valid || i_out_hdr !== prev_hdr)) begin
                $display("[FAIL] o_hdr changed while stalled: 0x%0h then 0x%0h valid %0b",
                         prev_hdr, i_out_hdr, i_out_hdr_valid);
                other_errors++;
            end
            if (pay_stalled && (!i_out_pay_valid || i_out_pay !== prev_pay)) begin
                $display("[FAIL] o_pay changed while stalled: 0x%0h then 0x%0h valid %0b",
                         prev_pay, i_out_pay, i_out_pay_valid);
                other_errors++;
            end

            // Input side of the model
            if (i_in_pay_valid && i_in_pay_ready) begin
                if (!in_frame) begin
                    $display("Payload beat accepted before its header at %0t", $time);
                    other_errors++;
                end else if (in_matched) begin
                    exp_pay_q.push_back(i_in_pay);
                end
                if (i_in_pay.last) begin
                    in_frame = 1'b0;
                end
            end else if (i_in_pay_valid && in_frame && !in_matched) begin
                $display("Payload of a discarded frame was held back at %0t", $time);
                other_errors++;
            end
            if (i_in_hdr_valid && i_in_hdr_ready) begin
                in_frame   = 1'b1;
                in_matched = (i_in_hdr.dst_port == `ECHO_PORT);
                if (in_matched) begin
                    exp_h.src_ip   = `LOCAL_IP;
                    exp_h.dst_ip   = i_in_hdr.src_ip;
                    exp_h.ttl      = `REPLY_TTL;
                    exp_h.src_port = i_in_hdr.dst_port;
                    exp_h.dst_port = i_in_hdr.src_port;
                    exp_h.length   = i_in_hdr.length;
                    exp_hdr_q.push_back(exp_h);
                end
            end else if (i_in_hdr_valid && !in_frame && i_in_hdr.dst_port != `ECHO_PORT) begin
                $display("Header for another port was not taken at once at %0t", $time);
                other_errors++;
            end

            // Output side
            if (i_out_hdr_valid && i_out_hdr_ready) begin
                hdr_count++;
                if (out_open || exp_hdr_q.size() == 0) begin
                    $display("Unexpected reply header 0x%0h at %0t", i_out_hdr, $time);
                    other_errors++;
                end else begin
                    exp_h = exp_hdr_q.pop_front();
                    hdr_errors += field_error("o_hdr_src_ip", i_out_hdr.src_ip, exp_h.src_ip);
                    hdr_errors += field_error("o_hdr_dst_ip", i_out_hdr.dst_ip, exp_h.dst_ip);
                    hdr_errors += field_error("o_hdr_ttl", i_out_hdr.ttl, exp_h.ttl);
                    hdr_errors += field_error("o_hdr_src_port", i_out_hdr.src_port,
                                              exp_h.src_port);
                    hdr_errors += field_error("o_hdr_dst_port", i_out_hdr.dst_port,
                                              exp_h.dst_port);
                    hdr_errors += field_error("o_hdr_length", i_out_hdr.length, exp_h.length);
                end
                out_open = 1'b1;
            end
            if (i_out_pay_valid && i_out_pay_ready) begin
                pay_count++;
                if (!out_open || exp_pay_q.size() == 0) begin
                    $display("Unexpected payload beat 0x%0h at %0t", i_out_pay, $time);
                    other_errors++;
                end else begin
                    exp_b = exp_pay_q.pop_front();
                    pay_errors += field_error("o_pay_data", i_out_pay.data, exp_b.data);
                    pay_errors += field_error("o_pay_last", i_out_pay.last, exp_b.last);
                    if (out_first) begin
                        led_expected = exp_b.data;
                        led_pending  = 1'b1;
                    end
                    out_first = exp_b.last;
                    out_open  = !exp_b.last;
                end
            end

            hdr_stalled = i_out_hdr_valid && !i_out_hdr_ready;
            pay_stalled = i_out_pay_valid && !i_out_pay_ready;
            prev_hdr    = i_out_hdr;
            prev_pay    = i_out_pay;
            o_pending   = exp_hdr_q.size() + exp_pay_q.size();

            if (i_done && !o_finished) begin
                if (o_pending != 0) begin
                    $display("Replies still expected at the end: %0d headers, %0d beats",
                             exp_hdr_q.size(), exp_pay_q.size());
                    other_errors++;
                end
                o_errors = hdr_errors + pay_errors + led_errors + other_errors;
                $display("Checked %0d headers, %0d beats: errors hdr %0d pay %0d led %0d other %0d",
                         hdr_count, pay_count, hdr_errors, pay_errors, led_errors,
                         other_errors);
                o_finished = 1'b1;
            end
        end
    end

endmodule

//--- verification/udp_echo_tb.sv
// UDP echo testbench
// Random frames to the echo port and to other ports, random output
// back-pressure, DUT instance and checker

`timescale 1ns/100ps

`include "udp_echo_config.svh"

module udp_echo_tb;

    localparam int FRAME_COUNT    = 200;
    localparam int TIMEOUT_CYCLES = FRAME_COUNT * 40 * 4;

    logic        clk;
    logic        rst;
    logic        i_hdr_valid;
    logic        o_hdr_ready;
    logic [31:0] i_hdr_src_ip;
    logic [31:0] i_hdr_dst_ip;
    logic [7:0]  i_hdr_ttl;
    logic [15:0] i_hdr_src_port;
    logic [15:0] i_hdr_dst_port;
    logic [15:0] i_hdr_length;
    logic        i_pay_valid;
    logic        o_pay_ready;
    logic [7:0]  i_pay_data;
    logic        i_pay_last;
    logic        o_hdr_valid;
    logic        i_hdr_ready;
    logic [31:0] o_hdr_src_ip;
    logic [31:0] o_hdr_dst_ip;
    logic [7:0]  o_hdr_ttl;
    logic [15:0] o_hdr_src_port;
    logic [15:0] o_hdr_dst_port;
    logic [15:0] o_hdr_length;
    logic        o_pay_valid;
    logic        i_pay_ready;
    logic [7:0]  o_pay_data;
    logic        o_pay_last;
    logic [7:0]  o_led;

    logic        done;
    logic        finished;
    int          pending;
    int          errors;
    int          cycles = 0;

    udp_echo_top udp_echo_top_i (.*);

    udp_echo_checker checker_i (
        .clk             (clk),
        .rst             (rst),
        .i_in_hdr_valid  (i_hdr_valid),
        .i_in_hdr_ready  (o_hdr_ready),
        .i_in_hdr        ({i_hdr_src_ip, i_hdr_dst_ip, i_hdr_ttl,
                           i_hdr_src_port, i_hdr_dst_port, i_hdr_length}),
        .i_in_pay_valid  (i_pay_valid),
        .i_in_pay_ready  (o_pay_ready),
        .i_in_pay        ({i_pay_data, i_pay_last}),
        .i_out_hdr_valid (o_hdr_valid),
        .i_out_hdr_ready (i_hdr_ready),
        .i_out_hdr       ({o_hdr_src_ip, o_hdr_dst_ip, o_hdr_ttl,
                           o_hdr_src_port, o_hdr_dst_port, o_hdr_length}),
        .i_out_pay_valid (o_pay_valid),
        .i_out_pay_ready (i_pay_ready),
        .i_out_pay       ({o_pay_data, o_pay_last}),
        .i_led           (o_led),
        .i_done          (done),
        .o_pending       (pending),
        .o_finished      (finished),
        .o_errors        (errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Valids stay low for n cycles
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_frame(input logic to_echo);
        int          nbytes;
        logic [15:0] other_port;
        logic        early_beat;
        nbytes     = 1 + int'($urandom % 32);
        other_port = 16'($urandom);
        early_beat = 1'($urandom % 2);
        if (other_port == `ECHO_PORT) begin
            other_port = other_port + 16'd1;
        end
        idle_cycles(int'($urandom % 3));
        i_hdr_src_ip   = $urandom;
        i_hdr_dst_ip   = $urandom;
        i_hdr_ttl      = 8'($urandom);
        i_hdr_src_port = 16'($urandom);
        i_hdr_dst_port = to_echo ? `ECHO_PORT : other_port;
        i_hdr_length   = 16'(8 + nbytes);
        i_hdr_valid    = 1'b1;
        // First beat may already wait beside its header
        if (early_beat) begin
            i_pay_data  = 8'($urandom);
            i_pay_last  = (nbytes == 1);
            i_pay_valid = 1'b1;
        end
        @(posedge clk);
        while (!o_hdr_ready) @(posedge clk);
        #2;
        i_hdr_valid = 1'b0;
        for (int b = 0; b < nbytes; b++) begin
            if (b != 0 || !early_beat) begin
                idle_cycles(int'($urandom % 2));
                i_pay_data  = 8'($urandom);
                i_pay_last  = (b == nbytes - 1);
                i_pay_valid = 1'b1;
            end
            @(posedge clk);
            while (!o_pay_ready) @(posedge clk);
            #2;
            i_pay_valid = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h4d54_c095));
        rst            = 1'b1;
        done           = 1'b0;
        i_hdr_valid    = 1'b0;
        i_hdr_src_ip   = '0;
        i_hdr_dst_ip   = '0;
        i_hdr_ttl      = '0;
        i_hdr_src_port = '0;
        i_hdr_dst_port = '0;
        i_hdr_length   = '0;
        i_pay_valid    = 1'b0;
        i_pay_data     = '0;
        i_pay_last     = 1'b0;
        i_hdr_ready    = 1'b0;
        i_pay_ready    = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int f = 0; f < FRAME_COUNT; f++) begin
            send_frame(($urandom % 2) == 1);
        end
        // Let the queued replies drain, then watch for stray output
        while (pending != 0) @(negedge clk);
        repeat (20) @(posedge clk);
        #2;
        done = 1'b1;
        while (!finished) @(negedge clk);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Output ready about three cycles in four
    initial begin
        @(negedge rst);
        forever begin
            @(posedge clk);
            #2;
            i_hdr_ready = ($urandom % 4) != 0;
            i_pay_ready = ($urandom % 4) != 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+common
common/udp_pkg.sv
common/stream_pkg.sv
common/udp_stream_if.sv
source/sync_fifo.sv
source/port_filter_fsm.sv
source/reply_sender.sv
source/udp_echo_top.sv
verification/udp_echo_checker.sv
verification/udp_echo_tb.sv
